/* include/aform_defs.svh */
`ifndef AFORM_DEFS_SVH
`define AFORM_DEFS_SVH

// Field start bits, numbered MSB first
`define AFORM_OP_POS   0
`define AFORM_T_POS    6
`define AFORM_A_POS    11
`define AFORM_B_POS    16
`define AFORM_C_POS    21
`define AFORM_XO_POS   26
`define AFORM_RC_POS   31

`define OPC_INT        6'd31
`define OPC_FP_DBL     6'd63
`define OPC_FP_SGL     6'd59

`define XO_ISEL        5'd15
`define XO_FDIV        5'd18
`define XO_FSUB        5'd20
`define XO_FADD        5'd21
`define XO_FSQRT       5'd22
`define XO_FSEL        5'd23
`define XO_FRE         5'd24
`define XO_FMUL        5'd25
`define XO_FRSQRTE     5'd26
`define XO_FMSUB       5'd28
`define XO_FMADD       5'd29
`define XO_FNMSUB      5'd30
`define XO_FNMADD      5'd31

`define UNIT_FX        3'd0
`define UNIT_FP        3'd1
`define UNIT_CR        3'd3

// Bit 0 is read and bit 1 is write
`define ACC_NONE       2'b00
`define ACC_READ       2'b10
`define ACC_WRITE      2'b01

`define AFORM_CREDITS  4

`endif

/* verilog/aformPkg.sv */
package aformPkg;

    // Instruction words and fields keep the MSB-first numbering
    typedef logic [0:31] instWord_t;     // One fixed-size instruction

    typedef logic [0:5]  opcode_t;       // Primary opcode

    typedef logic [0:4]  xo_t;           // Extended opcode

    typedef logic [0:4]  regIdx_t;       // T, A, B or C field

    // Program order tag shared by all micro ops of one instruction
    typedef logic [0:63] majId_t;

    typedef logic [0:2]  funcUnit_t;     // Backend unit class

    // Operand access pattern
    // Bit 0 set when the operand is read
    // Bit 1 set when the operand is written
    typedef logic [0:1]  regAccess_t;

    // Free entries in the issue queue
    typedef logic [2:0]  credit_t;       // Holds 0 to 4

endpackage

/* verilog/aformOpDecode.sv */
`include "aform_defs.svh"

module aformOpDecode (
    input  aformPkg::opcode_t    opcode_i,
    input  aformPkg::xo_t        xo_i,
    input  aformPkg::regIdx_t    regA_i,
    output logic                 legal_o,
    output aformPkg::funcUnit_t  funcUnit_o,
    output logic                 aIsReg_o,
    output aformPkg::regAccess_t accessT_o,
    output aformPkg::regAccess_t accessA_o,
    output aformPkg::regAccess_t accessB_o,
    output aformPkg::regAccess_t accessC_o
);

    logic isSelect;     // Integer select
    logic isFloat;      // Either floating opcode
    logic fpBasic;      // Floating ops on A and B only
    logic fpMulAdd;     // Floating ops that also read C

    assign isSelect = (opcode_i == `OPC_INT) && (xo_i == `XO_ISEL);
    assign isFloat  = (opcode_i == `OPC_FP_DBL) || (opcode_i == `OPC_FP_SGL);

    // Both floating groups share one XO table.
    // Floating select exists only in double precision
    always_comb begin
        fpBasic  = 1'b0;
        fpMulAdd = 1'b0;
        if (isFloat) begin
            case (xo_i)
                `XO_FDIV,
                `XO_FSUB,
                `XO_FADD,
                `XO_FSQRT,
                `XO_FRE,
                `XO_FMUL,
                `XO_FRSQRTE: begin
                    fpBasic = 1'b1;
                end
                `XO_FMSUB,
                `XO_FMADD,
                `XO_FNMSUB,
                `XO_FNMADD: begin
                    fpMulAdd = 1'b1;
                end
                `XO_FSEL: begin
                    fpMulAdd = (opcode_i == `OPC_FP_DBL);   // Selects on C like FMA
                end
                default: begin
                    fpBasic  = 1'b0;
                    fpMulAdd = 1'b0;
                end
            endcase
        end
    end

    assign legal_o = isSelect || fpBasic || fpMulAdd;

    // Illegal words fall back to the integer unit code
    always_comb begin
        if (isSelect) begin
            funcUnit_o = `UNIT_CR;
        end else if (legal_o) begin
            funcUnit_o = `UNIT_FP;
        end else begin
            funcUnit_o = `UNIT_FX;
        end
    end

    // isel treats RA of zero as the literal zero
    assign aIsReg_o = !(isSelect && (regA_i == '0));

    assign accessT_o = legal_o ? `ACC_WRITE : `ACC_NONE;
    assign accessA_o = legal_o ? `ACC_READ : `ACC_NONE;
    assign accessB_o = legal_o ? `ACC_READ : `ACC_NONE;
    assign accessC_o = (isSelect || fpMulAdd) ? `ACC_READ : `ACC_NONE;

endmodule

/* verilog/aformDecodeStage.sv */
`include "aform_defs.svh"

module aformDecodeStage (
    input  logic                 clock_i,
    input  logic                 rstN_i,
    input  logic                 instValid_i,
    input  aformPkg::instWord_t  instWord_i,
    input  aformPkg::majId_t     majId_i,
    input  logic                 canAccept_i,
    output logic                 recValid_o,
    output logic                 illegalInst_o,
    output aformPkg::opcode_t    opcode_o,
    output aformPkg::xo_t        xo_o,
    output aformPkg::regIdx_t    regT_o,
    output aformPkg::regIdx_t    regA_o,
    output aformPkg::regIdx_t    regB_o,
    output aformPkg::regIdx_t    regC_o,
    output logic                 rc_o,
    output aformPkg::majId_t     majId_o,
    output aformPkg::funcUnit_t  funcUnit_o,
    output logic                 aIsReg_o,
    output aformPkg::regAccess_t accessT_o,
    output aformPkg::regAccess_t accessA_o,
    output aformPkg::regAccess_t accessB_o,
    output aformPkg::regAccess_t accessC_o
);

    import aformPkg::*;

    opcode_t    opcode;
    xo_t        xo;
    regIdx_t    regT;
    regIdx_t    regA;
    regIdx_t    regB;
    regIdx_t    regC;
    logic       rc;
    logic       accept;
    logic       legal;
    funcUnit_t  funcUnit;
    logic       aIsReg;
    regAccess_t accessT;
    regAccess_t accessA;
    regAccess_t accessB;
    regAccess_t accessC;

    // Field split
    assign opcode = instWord_i[`AFORM_OP_POS +: $bits(opcode_t)];
    assign regT   = instWord_i[`AFORM_T_POS +: $bits(regIdx_t)];
    assign regA   = instWord_i[`AFORM_A_POS +: $bits(regIdx_t)];
    assign regB   = instWord_i[`AFORM_B_POS +: $bits(regIdx_t)];
    assign regC   = instWord_i[`AFORM_C_POS +: $bits(regIdx_t)];
    assign xo     = instWord_i[`AFORM_XO_POS +: $bits(xo_t)];
    assign rc     = instWord_i[`AFORM_RC_POS];

    assign accept = instValid_i && canAccept_i;

    aformOpDecode opDecode (
        .opcode_i   (opcode),
        .xo_i       (xo),
        .regA_i     (regA),
        .legal_o    (legal),
        .funcUnit_o (funcUnit),
        .aIsReg_o   (aIsReg),
        .accessT_o  (accessT),
        .accessA_o  (accessA),
        .accessB_o  (accessB),
        .accessC_o  (accessC)
    );

    // One pulse per accepted word, record or illegal
    always_ff @(posedge clock_i) begin
        if (!rstN_i) begin
            recValid_o    <= 1'b0;
            illegalInst_o <= 1'b0;
        end else begin
            recValid_o    <= accept && legal;
            illegalInst_o <= accept && !legal;
        end
    end

    // Record payload holds its value until the next legal word
    always_ff @(posedge clock_i) begin
        if (accept && legal) begin
            opcode_o   <= opcode;
            xo_o       <= xo;
            regT_o     <= regT;
            regA_o     <= regA;
            regB_o     <= regB;
            regC_o     <= regC;
            rc_o       <= rc;
            majId_o    <= majId_i;
            funcUnit_o <= funcUnit;
            aIsReg_o   <= aIsReg;
            accessT_o  <= accessT;
            accessA_o  <= accessA;
            accessB_o  <= accessB;
            accessC_o  <= accessC;
        end
    end

endmodule

/* verilog/issueCreditCounter.sv */
`include "aform_defs.svh"

module issueCreditCounter #(
    parameter int creditMax = `AFORM_CREDITS
) (
    input  logic clock_i,
    input  logic rstN_i,
    input  logic spend_i,           // Record visible this cycle
    input  logic creditReturn_i,    // Queue freed one entry
    output logic canAccept_o
);

    import aformPkg::*;

    credit_t creditCount;   // Excludes the record now on the output
    credit_t creditFree;    // Credits left once that record is counted

    // spend_i comes from the registered record valid, so the record
    // leaving this cycle is charged at once through creditFree and
    // folded into the stored count at the next edge
    always_ff @(posedge clock_i) begin
        if (!rstN_i) begin
            creditCount <= credit_t'(creditMax);
        end else begin
            case ({spend_i, creditReturn_i})
                2'b10:   creditCount <= creditCount - credit_t'(1);
                2'b01:   creditCount <= creditCount + credit_t'(1);
                default: creditCount <= creditCount;   // Idle or both
            endcase
        end
    end

    assign creditFree  = creditCount - credit_t'(spend_i);
    assign canAccept_o = (creditFree != '0);

endmodule

/* verilog/aformDecoder.sv */
module aformDecoder (
    input  logic                 clock_i,
    input  logic                 rstN_i,
    input  logic                 instValid_i,
    input  aformPkg::instWord_t  instWord_i,
    input  aformPkg::majId_t     majId_i,
    input  logic                 creditReturn_i,
    output logic                 instReady_o,
    output logic                 recValid_o,
    output logic                 illegalInst_o,
    output aformPkg::opcode_t    opcode_o,
    output aformPkg::xo_t        xo_o,
    output aformPkg::regIdx_t    regT_o,
    output aformPkg::regIdx_t    regA_o,
    output aformPkg::regIdx_t    regB_o,
    output aformPkg::regIdx_t    regC_o,
    output logic                 rc_o,
    output aformPkg::majId_t     majId_o,
    output aformPkg::funcUnit_t  funcUnit_o,
    output logic                 aIsReg_o,
    output aformPkg::regAccess_t accessT_o,
    output aformPkg::regAccess_t accessA_o,
    output aformPkg::regAccess_t accessB_o,
    output aformPkg::regAccess_t accessC_o
);

    logic canAccept;    // A free slot in the issue queue

    assign instReady_o = canAccept;

    aformDecodeStage decodeStage (
        .clock_i       (clock_i),
        .rstN_i        (rstN_i),
        .instValid_i   (instValid_i),
        .instWord_i    (instWord_i),
        .majId_i       (majId_i),
        .canAccept_i   (canAccept),
        .recValid_o    (recValid_o),
        .illegalInst_o (illegalInst_o),
        .opcode_o      (opcode_o),
        .xo_o          (xo_o),
        .regT_o        (regT_o),
        .regA_o        (regA_o),
        .regB_o        (regB_o),
        .regC_o        (regC_o),
        .rc_o          (rc_o),
        .majId_o       (majId_o),
        .funcUnit_o    (funcUnit_o),
        .aIsReg_o      (aIsReg_o),
        .accessT_o     (accessT_o),
        .accessA_o     (accessA_o),
        .accessB_o     (accessB_o),
        .accessC_o     (accessC_o)
    );

    // Only emitted records use a queue entry
    issueCreditCounter creditCounter (
        .clock_i        (clock_i),
        .rstN_i         (rstN_i),
        .spend_i        (recValid_o),
        .creditReturn_i (creditReturn_i),
        .canAccept_o    (canAccept)
    );

endmodule

/* testbench/aformDecoderChk.sv */
module aformDecoderChk (
    input logic clock_i,
    input logic rstN_i,
    input logic instValid_i,
    input logic instReady_i,
    input logic recValid_i,
    input logic illegalInst_i
);

    // Counter comes out of reset full
    readyAfterReset: assert property (
        @(posedge clock_i) !rstN_i |=> instReady_i
    ) else $error("instReady_o is low in the cycle after reset");

    // A word is either a record or an illegal pulse
    singleResult: assert property (
        @(posedge clock_i) disable iff (!rstN_i)
        !(recValid_i && illegalInst_i)
    ) else $error("recValid_o and illegalInst_o are high together");

    // A refused word must leave no trace on the output side
    noTransferWhenBusy: assert property (
        @(posedge clock_i) disable iff (!rstN_i)
        (instValid_i && !instReady_i) |=> !(recValid_i || illegalInst_i)
    ) else $error("Output pulse for a word offered while instReady_o was low");

endmodule

bind aformDecoder aformDecoderChk handshakeChk (
    .clock_i       (clock_i),
    .rstN_i        (rstN_i),
    .instValid_i   (instValid_i),
    .instReady_i   (instReady_o),
    .recValid_i    (recValid_o),
    .illegalInst_i (illegalInst_o)
);

/* testbench/aformDecoderTb.sv */
`include "aform_defs.svh"

module aformDecoderTb;

    import aformPkg::*;

    localparam int numInst    = 2000;
    localparam int cycleLimit = numInst * 10;  // Room for long credit starvation

    typedef struct packed {
        instWord_t word;
        majId_t    majId;
    } xfer_t;

    logic clock_i;
    logic rstN_i;
    logic instValid_i;
    instWord_t instWord_i;
    majId_t majId_i;
    logic creditReturn_i;
    logic instReady_o;
    logic recValid_o;
    logic illegalInst_o;
    opcode_t opcode_o;
    xo_t xo_o;
    regIdx_t regT_o;
    regIdx_t regA_o;
    regIdx_t regB_o;
    regIdx_t regC_o;
    logic rc_o;
    majId_t majId_o;
    funcUnit_t funcUnit_o;
    logic aIsReg_o;
    regAccess_t accessT_o;
    regAccess_t accessA_o;
    regAccess_t accessB_o;
    regAccess_t accessC_o;

    integer seed;
    xfer_t pending[$];          // Accepted words awaiting their output cycle
    int held = 0;               // Records the issue queue has not freed yet
    int accepted = 0;
    int starveLeft = 0;
    int cycleCount = 0;
    int legalSeen = 0;
    int illegalSeen = 0;
    logic nextValid;
    instWord_t nextWord;
    majId_t nextMajId;
    logic retNext;

    aformDecoder dut (.*);

    always #10 clock_i = ~clock_i;

    function automatic int randRange(input int n);
        return int'($unsigned($random(seed)) % $unsigned(n));
    endfunction

    // Index 4 of the floating XO list is fsel
    function automatic xo_t fpXoAt(input int idx);
        return xo_t'(idx == 0 ? 18 : (idx < 8 ? 19 + idx : 20 + idx));
    endfunction

    function automatic logic legalPair(input opcode_t op, input xo_t xo);
        logic fpOk;
        fpOk = xo inside {5'd18, [5'd20:5'd26], [5'd28:5'd31]};
        case (op)
            6'd31:   return xo == 5'd15;
            6'd63:   return fpOk;
            6'd59:   return fpOk && (xo != 5'd23);
            default: return 1'b0;
        endcase
    endfunction

    // isel and the multiply-add family read C
    function automatic logic readsC(input opcode_t op, input xo_t xo);
        return (op == 6'd31) || (xo >= 5'd28) || (op == 6'd63 && xo == 5'd23);
    endfunction

    function automatic instWord_t makeWord();
        int kind;
        int idx;
        opcode_t op;
        xo_t xo;
        regIdx_t regA;
        kind = randRange(100);
        regA = regIdx_t'($random(seed));
        xo   = xo_t'($random(seed));
        idx  = randRange(3);
        op   = (idx == 0) ? 6'd31 : ((idx == 1) ? 6'd63 : 6'd59);
        if (kind < 70) begin
            if (idx == 0) begin
                xo = 5'd15;
                if (randRange(4) == 0) begin
                    regA = '0;      // isel with literal zero
                end
            end else if (idx == 1) begin
                xo = fpXoAt(randRange(12));
            end else begin
                kind = randRange(11);
                xo   = fpXoAt(kind >= 4 ? kind + 1 : kind);    // Skip fsel
            end
        end else if (kind >= 85) begin
            op = opcode_t'($random(seed));
        end
        return {op, regIdx_t'($random(seed)), regA, regIdx_t'($random(seed)),
                regIdx_t'($random(seed)), xo, 1'($random(seed))};
    endfunction

    task automatic abortRun();
        $display("Simulation failed");
        $fatal(1, "Run stopped at the first error");
    endtask

    task automatic checkBit(input string name, input logic expV, input logic actV);
        if (actV !== expV) begin
            $display("Fail at time %0t: %s expected %b, got %b", $time, name, expV, actV);
            abortRun();
        end
    endtask

    task automatic checkReg(input string name, input regIdx_t expV, input regIdx_t actV);
        if (actV !== expV) begin
            $display("Fail at time %0t: %s expected %0d, got %0d", $time, name, expV, actV);
            abortRun();
        end
    endtask

    task automatic checkOpcode(input string name, input opcode_t expV, input opcode_t actV);
        if (actV !== expV) begin
            $display("Fail at time %0t: %s expected %0d, got %0d", $time, name, expV, actV);
            abortRun();
        end
    endtask

    task automatic checkXo(input string name, input xo_t expV, input xo_t actV);
        if (actV !== expV) begin
            $display("Fail at time %0t: %s expected %0d, got %0d", $time, name, expV, actV);
            abortRun();
        end
    endtask

    task automatic checkUnit(input string name, input funcUnit_t expV, input funcUnit_t actV);
        if (actV !== expV) begin
            $display("Fail at time %0t: %s expected %0d, got %0d", $time, name, expV, actV);
            abortRun();
        end
    endtask

    task automatic checkAccess(input string name, input regAccess_t expV,
                               input regAccess_t actV);
        if (actV !== expV) begin
            $display("Fail at time %0t: %s expected %b, got %b", $time, name, expV, actV);
            abortRun();
        end
    endtask

    task automatic checkMajId(input string name, input majId_t expV, input majId_t actV);
        if (actV !== expV) begin
            $display("Fail at time %0t: %s expected %h, got %h", $time, name, expV, actV);
            abortRun();
        end
    endtask

    // One cycle after acceptance the word shows up as a record or an illegal pulse
    task automatic checkOutputs();
        xfer_t taken;
        instWord_t w;
        logic legal;
        if (pending.size() == 0) begin
            checkBit("recValid_o", 1'b0, recValid_o);
            checkBit("illegalInst_o", 1'b0, illegalInst_o);
        end else begin
            taken = pending.pop_front();
            w     = taken.word;
            legal = legalPair(w[0:5], w[26:30]);
            checkBit("recValid_o", legal, recValid_o);
            checkBit("illegalInst_o", !legal, illegalInst_o);
            if (legal) begin
                legalSeen++;
                checkOpcode("opcode_o", w[0:5], opcode_o);
                checkXo("xo_o", w[26:30], xo_o);
                checkReg("regT_o", w[6:10], regT_o);
                checkReg("regA_o", w[11:15], regA_o);
                checkReg("regB_o", w[16:20], regB_o);
                checkReg("regC_o", w[21:25], regC_o);
                checkBit("rc_o", w[31], rc_o);
                checkMajId("majId_o", taken.majId, majId_o);
                checkUnit("funcUnit_o", (w[0:5] == 6'd31) ? `UNIT_CR : `UNIT_FP, funcUnit_o);
                checkBit("aIsReg_o", !(w[0:5] == 6'd31 && w[11:15] == 5'd0), aIsReg_o);
                checkAccess("accessT_o", `ACC_WRITE, accessT_o);
                checkAccess("accessA_o", `ACC_READ, accessA_o);
                checkAccess("accessB_o", `ACC_READ, accessB_o);
                checkAccess("accessC_o", readsC(w[0:5], w[26:30]) ? `ACC_READ : `ACC_NONE,
                            accessC_o);
            end else begin
                illegalSeen++;
            end
        end
    endtask

    task automatic pickStimulus();
        if (instValid_i && !instReady_o) begin
            nextValid = 1'b1;       // Hold the refused word
        end else if (accepted < numInst && randRange(100) < 85) begin
            nextValid = 1'b1;
            nextWord  = makeWord();
            nextMajId = {$random(seed), $random(seed)};
        end else begin
            nextValid = 1'b0;
        end
    endtask

    always @(posedge clock_i) begin
        cycleCount <= cycleCount + 1;
        if (cycleCount >= cycleLimit) begin
            $display("Timeout after %0d cycles with %0d of %0d instructions accepted",
                     cycleLimit, accepted, numInst);
            abortRun();
        end
    end

    initial begin
        xfer_t offered;
        seed           = 32'h688abc1f;
        clock_i        = 1'b0;
        rstN_i         = 1'b0;
        instValid_i    = 1'b0;
        instWord_i     = '0;
        majId_i        = '0;
        creditReturn_i = 1'b0;
        nextWord       = '0;
        nextMajId      = '0;
        repeat (5) @(posedge clock_i);
        rstN_i <= 1'b1;
        while (accepted < numInst || held != 0 || pending.size() != 0) begin
            @(negedge clock_i);
            checkOutputs();
            if (recValid_o) begin
                held++;             // Record now sits in the issue queue
            end
            checkBit("instReady_o", held < `AFORM_CREDITS, instReady_o);
            if (creditReturn_i) begin
                held--;             // Counted at the coming edge
            end
            if (instValid_i && instReady_o) begin
                offered.word  = instWord_i;
                offered.majId = majId_i;
                pending.push_back(offered);
                accepted++;
            end
            if (starveLeft > 0) begin
                starveLeft--;
            end else if (randRange(100) < 3) begin
                starveLeft = 8 + randRange(40);
            end
            retNext = (held > 0) && (starveLeft == 0) && (randRange(2) == 0);
            pickStimulus();
            @(posedge clock_i);
            instValid_i    <= nextValid;
            instWord_i     <= nextWord;
            majId_i        <= nextMajId;
            creditReturn_i <= retNext;
        end
        @(negedge clock_i);
        checkBit("instReady_o", 1'b1, instReady_o);
        checkBit("recValid_o", 1'b0, recValid_o);
        checkBit("illegalInst_o", 1'b0, illegalInst_o);
        $display("Checked %0d legal and %0d illegal instructions", legalSeen, illegalSeen);
        $display("Simulation passed");
        $finish;
    end

endmodule

/* sources.f */
+incdir+include
verilog/aformPkg.sv
verilog/aformOpDecode.sv
verilog/aformDecodeStage.sv
verilog/issueCreditCounter.sv
verilog/aformDecoder.sv
testbench/aformDecoderChk.sv
testbench/aformDecoderTb.sv

/* run.sh */
#!/usr/bin/env bash
set -e

cd "$(dirname "$0")"

rm -rf obj_dir sim.log

verilator --binary --assert --timing \
    -f sources.f \
    --top-module aformDecoderTb \
    -o aformDecoderSim

./obj_dir/aformDecoderSim | tee sim.log

if grep -qx "Simulation passed" sim.log; then
    echo "run.sh: pass message found in sim.log"
else
    echo "run.sh: pass message missing, see sim.log"
    exit 1
fi
